// File: bench/uart_debug_unit_tb.sv
`timescale 1ns/1ps

module uart_debug_unit_tb import dbg_pkg::*; ();

    // worst case cycles of one byte with its gap, one dump and one freeze
    localparam int BYTE_WC   = 7;
    localparam int DUMP_WC   = SNAP_BYTES * 10 + 8;
    localparam int FREEZE_WC = 4;
    // command plus up to 11 words of 4 bytes
    localparam int LOAD_WC   = 45 * BYTE_WC + 8;
    localparam int TESTS_WC  = LOAD_WC + (8 * BYTE_WC + 8 + LOAD_WC)
        + (BYTE_WC + 3 * (FREEZE_WC + BYTE_WC + DUMP_WC))
        + (FREEZE_WC + BYTE_WC + DUMP_WC + 4)
        + (FREEZE_WC + BYTE_WC + 34 + DUMP_WC + 4) + 6;
    localparam int MAX_CYCLES = 2 * (TESTS_WC + 3);

    logic      clk;
    logic      i_rst_n;
    logic      i_rx_done;
    byte_t     i_rx;
    logic      i_tx_done;
    logic      i_end;
    snapshot_t i_snapshot;
    logic      o_tx_start;
    byte_t     o_tx_data;
    instr_wr_t o_instr;
    logic      o_step;
    logic      o_start;

    // logged by the monitor on falling edges
    byte_t tx_bytes[$];
    word_t wr_instr[$];
    word_t wr_addr[$];
    int    step_hi = 0;
    int    start_hi = 0;
    int    bp_errors = 0;
    logic  tx_busy = 1'b0;
    // main flow
    logic      hold_snap = 1'b0;
    snapshot_t snap_exp;
    int        errors = 0;
    int        failed_tests = 0;
    int        cycles = 0;

    uart_debug_unit dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    function automatic snapshot_t random_snapshot();
        logic [32*9-1:0] acc;
        for (int k = 0; k < 9; k++) begin
            acc[32*k +: 32] = $urandom;
        end
        return acc[$bits(snapshot_t)-1:0];
    endfunction

    // core latches keep changing unless a dump is pending
    initial begin
        i_snapshot = '0;
        forever begin
            @(negedge clk);
            if (!hold_snap) begin
                i_snapshot = random_snapshot();
            end
        end
    end

    // transmitter answers each start after 1 to 8 cycles and the monitor logs outputs
    initial begin
        int delay;
        i_tx_done = 1'b0;
        delay = 0;
        forever begin
            @(negedge clk);
            i_tx_done = 1'b0;
            if (o_tx_start) begin
                if (tx_busy) begin
                    $display("tx start at %0t came before tx done of the previous byte", $time);
                    bp_errors++;
                end
                tx_bytes.push_back(o_tx_data);
                tx_busy = 1'b1;
                delay = 1 + int'($urandom % 8);
            end else if (tx_busy) begin
                delay--;
                if (delay == 0) begin
                    i_tx_done = 1'b1;
                    tx_busy = 1'b0;
                end
            end
            if (o_instr.wr) begin
                wr_instr.push_back(o_instr.instr);
                wr_addr.push_back(o_instr.addr);
            end
            step_hi += int'(o_step);
            start_hi += int'(o_start);
        end
    end

    // gap of 2 to 6 cycles, then one strobed byte
    task automatic send_byte(input byte_t b);
        int gap;
        gap = 2 + int'($urandom % 5);
        repeat (gap) @(negedge clk);
        i_rx = b;
        i_rx_done = 1'b1;
        @(negedge clk);
        i_rx_done = 1'b0;
    endtask

    // mode entry raises o_start on the edge that takes the command
    task automatic expect_start(input logic exp);
        if (o_start !== exp) begin
            $display("Fail t=%0t o_start got %b expected %b", $time, o_start, exp);
            errors++;
        end
    endtask

    // one fresh random value, then held until the dump is over
    task automatic freeze_snapshot();
        repeat (2) @(negedge clk);
        hold_snap = 1'b1;
        @(negedge clk);
        snap_exp = i_snapshot;
    endtask

    task automatic wait_dump(input int base);
        while (tx_bytes.size() < base + SNAP_BYTES || tx_busy) @(negedge clk);
    endtask

    task automatic check_dump(input int base, input snapshot_t s);
        logic [8*SNAP_BYTES-1:0] flat;
        // id_ex leaves first and control last, each group lowest byte first
        flat = {s.control, s.wb_id, s.mem_wb, s.ex_mem, s.id_ex};
        if (tx_bytes.size() != base + SNAP_BYTES) begin
            $display("dump sent %0d bytes instead of %0d", tx_bytes.size() - base, SNAP_BYTES);
            errors++;
        end else begin
            for (int k = 0; k < SNAP_BYTES; k++) begin
                if (tx_bytes[base+k] !== flat[8*k +: 8]) begin
                    $display("Fail t=%0t o_tx_data byte %0d got %h expected %h",
                        $time, k, tx_bytes[base+k], flat[8*k +: 8]);
                    errors++;
                end
            end
        end
    endtask

    // random words plus the halt word with the first byte most significant
    task automatic run_load(input int n);
        word_t words[$];
        word_t w;
        int    base;
        @(posedge clk);
        base = wr_instr.size();
        for (int i = 0; i < n; i++) begin
            w = word_t'($urandom);
            words.push_back((w == HALT_INSTR) ? word_t'(0) : w);
        end
        words.push_back(HALT_INSTR);
        send_byte(CMD_LOAD);
        expect_start(1'b1);
        foreach (words[i]) begin
            w = words[i];
            for (int b = 3; b >= 0; b--) begin
                send_byte(w[8*b +: 8]);
            end
        end
        while (o_start) @(negedge clk);
        if (wr_instr.size() != base + words.size()) begin
            $display("load gave %0d writes, %0d expected", wr_instr.size() - base, words.size());
            errors++;
        end else begin
            foreach (words[i]) begin
                if (wr_instr[base+i] !== words[i] || wr_addr[base+i] !== word_t'(4 * i)) begin
                    $display("Fail t=%0t o_instr got %h@%h expected %h@%h", $time,
                        wr_instr[base+i], wr_addr[base+i], words[i], word_t'(4 * i));
                    errors++;
                end
            end
        end
    endtask

    task automatic report(input int num, input string name, input int err_before);
        $display("test %0d %s: %0d errors", num, name, errors - err_before);
        if (errors != err_before) begin
            failed_tests++;
        end
    endtask

    initial begin
        int    e0;
        int    base;
        int    s0;
        int    w0;
        int    k;
        byte_t b;
        void'($urandom(32'hfe94_798f));
        i_rst_n = 1'b0;
        i_rx_done = 1'b0;
        i_rx = '0;
        i_end = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;

        e0 = errors;
        run_load(5 + int'($urandom % 6));
        report(1, "program load", e0);

        // bytes outside the command set are dropped in idle
        e0 = errors;
        @(posedge clk);
        base = tx_bytes.size();
        w0 = wr_instr.size();
        s0 = start_hi;
        repeat (8) begin
            b = byte_t'($urandom);
            while (b == CMD_LOAD || b == CMD_DEBUG || b == CMD_RUN || b == CMD_STEP ||
                   b == CMD_END_DEBUG) begin
                b = byte_t'($urandom);
            end
            send_byte(b);
        end
        repeat (4) @(negedge clk);
        @(posedge clk);
        if (wr_instr.size() != w0 || tx_bytes.size() != base || start_hi != s0) begin
            $display("noise bytes in idle caused a write, a transmit or a start");
            errors++;
        end
        run_load(5 + int'($urandom % 6));
        report(2, "ignored bytes", e0);

        e0 = errors;
        send_byte(CMD_DEBUG);
        expect_start(1'b1);
        repeat (3) begin
            freeze_snapshot();
            @(posedge clk);
            base = tx_bytes.size();
            s0 = step_hi;
            send_byte(CMD_STEP);
            wait_dump(base);
            @(posedge clk);
            if (step_hi - s0 != 1) begin
                $display("Fail t=%0t o_step high cycles got %0d expected 1", $time, step_hi - s0);
                errors++;
            end
            check_dump(base, snap_exp);
            hold_snap = 1'b0;
        end
        report(3, "debug step", e0);

        e0 = errors;
        freeze_snapshot();
        @(posedge clk);
        base = tx_bytes.size();
        s0 = step_hi;
        send_byte(CMD_END_DEBUG);
        wait_dump(base);
        while (o_start) @(negedge clk);
        @(posedge clk);
        if (step_hi != s0) begin
            $display("Fail t=%0t o_step high cycles got %0d expected 0", $time, step_hi - s0);
            errors++;
        end
        check_dump(base, snap_exp);
        hold_snap = 1'b0;
        report(4, "end of debug", e0);

        // step held high until the core reports its end
        e0 = errors;
        freeze_snapshot();
        send_byte(CMD_RUN);
        expect_start(1'b1);
        while (!o_step) @(negedge clk);
        k = 5 + int'($urandom % 26);
        repeat (k) begin
            @(negedge clk);
            if (!o_step) begin
                $display("Fail t=%0t o_step got 0 expected 1", $time);
                errors++;
            end
        end
        i_end = 1'b1;
        @(posedge clk);
        base = tx_bytes.size();
        s0 = step_hi;
        wait_dump(base);
        while (o_start) @(negedge clk);
        @(posedge clk);
        if (step_hi != s0) begin
            $display("Fail t=%0t o_step high cycles after i_end got %0d expected 0",
                $time, step_hi - s0);
            errors++;
        end
        check_dump(base, snap_exp);
        i_end = 1'b0;
        hold_snap = 1'b0;
        report(5, "continuous run", e0);

        // five dumps in total so any stray start shows up here
        e0 = errors;
        repeat (4) @(negedge clk);
        @(posedge clk);
        errors += bp_errors;
        if (tx_bytes.size() != 5 * SNAP_BYTES || tx_busy) begin
            $display("transmitter saw %0d bytes over all dumps, %0d expected",
                tx_bytes.size(), 5 * SNAP_BYTES);
            errors++;
        end
        report(6, "transmit back-pressure", e0);

        $display("tests 6, failed %0d, errors %0d, cycles %0d", failed_tests, errors, cycles);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: logic/dbg_pkg.sv
package dbg_pkg;

    // basic widths of the serial link and the instruction path
    localparam int NB_BYTE = 8;
    localparam int NB_WORD = 32;

    // one uart byte and one instruction word or address
    typedef logic [NB_BYTE-1:0] byte_t;
    typedef logic [NB_WORD-1:0] word_t;

    // all ones word closes a program load
    localparam word_t HALT_INSTR = 32'hffff_ffff;

    // command bytes, one hot
    localparam byte_t CMD_LOAD      = 8'h01;
    localparam byte_t CMD_DEBUG     = 8'h02;
    localparam byte_t CMD_RUN       = 8'h04;
    localparam byte_t CMD_STEP      = 8'h08;
    localparam byte_t CMD_END_DEBUG = 8'h10;

    // pipeline latch group widths
    localparam int NB_ID_EX   = 144;
    localparam int NB_EX_MEM  = 32;
    localparam int NB_MEM_WB  = 40;
    localparam int NB_WB_ID   = 40;
    localparam int NB_CONTROL = 24;

    // bytes in one full dump and the counter that walks them
    localparam int SNAP_BYTES  = 35;
    localparam int NB_SNAP_CNT = $clog2(SNAP_BYTES + 1);
    typedef logic [NB_SNAP_CNT-1:0] snap_cnt_t;

    // id_ex sits lowest so it leaves first
    typedef struct packed {
        logic [NB_CONTROL-1:0] control;
        logic [NB_WB_ID-1:0]   wb_id;
        logic [NB_MEM_WB-1:0]  mem_wb;
        logic [NB_EX_MEM-1:0]  ex_mem;
        logic [NB_ID_EX-1:0]   id_ex;
    } snapshot_t;

    // received byte with its done strobe
    typedef struct packed {
        logic  strobe;
        byte_t data;
    } rx_byte_t;

    // write port into instruction memory
    typedef struct packed {
        logic  wr;
        word_t instr;
        word_t addr;
    } instr_wr_t;

    // debug front end modes
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_DEBUG,
        ST_RUN,
        ST_DUMP
    } ctrl_state_t;

endpackage

// File: logic/debug_ctrl.sv
`timescale 1ns/1ps

module debug_ctrl import dbg_pkg::*; (
    input  logic     clk,
    input  logic     i_rst_n,
    input  rx_byte_t i_rx,
    input  logic     i_halt,
    input  logic     i_end,
    input  logic     i_dump_done,
    output rx_byte_t o_load_byte,
    output logic     o_load_start,
    output logic     o_dump_req,
    output logic     o_step,
    output logic     o_start
);

    ctrl_state_t state, next_state;
    // set when the running dump should fall back into debug mode
    logic ret_debug, next_ret_debug;
    logic step, next_step;
    logic start, next_start;
    logic dump_req, next_dump_req;
    logic load_start, next_load_start;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= ST_IDLE;
            ret_debug  <= 1'b0;
            step       <= 1'b0;
            start      <= 1'b0;
            dump_req   <= 1'b0;
            load_start <= 1'b0;
        end else begin
            state      <= next_state;
            ret_debug  <= next_ret_debug;
            step       <= next_step;
            start      <= next_start;
            dump_req   <= next_dump_req;
            load_start <= next_load_start;
        end
    end

    always_comb begin
        // pulses default low, step is only held in run mode
        next_state      = state;
        next_ret_debug  = ret_debug;
        next_step       = 1'b0;
        next_start      = start;
        next_dump_req   = 1'b0;
        next_load_start = 1'b0;

        case (state)
            ST_IDLE: begin
                if (i_rx.strobe) begin
                    case (i_rx.data)
                        CMD_LOAD: begin
                            next_state      = ST_LOAD;
                            next_start      = 1'b1;
                            next_load_start = 1'b1;
                        end
                        CMD_DEBUG: begin
                            next_state = ST_DEBUG;
                            next_start = 1'b1;
                        end
                        CMD_RUN: begin
                            next_state = ST_RUN;
                            next_start = 1'b1;
                            next_step  = 1'b1;
                        end
                        // anything else is noise on the line
                        default: next_state = ST_IDLE;
                    endcase
                end
            end

            ST_LOAD: begin
                // halt word has just been written
                if (i_halt) begin
                    next_state = ST_IDLE;
                    next_start = 1'b0;
                end
            end

            ST_DEBUG: begin
                // the cycle after a step pulse the core has moved, grab it
                if (step) begin
                    next_dump_req  = 1'b1;
                    next_ret_debug = 1'b1;
                    next_state     = ST_DUMP;
                end else if (i_rx.strobe) begin
                    if (i_rx.data == CMD_STEP) begin
                        next_step = 1'b1;
                    end else if (i_rx.data == CMD_END_DEBUG) begin
                        // final dump without a step
                        next_dump_req  = 1'b1;
                        next_ret_debug = 1'b0;
                        next_state     = ST_DUMP;
                    end
                end
            end

            ST_RUN: begin
                // free running until the core reports the end
                if (i_end) begin
                    next_dump_req  = 1'b1;
                    next_ret_debug = 1'b0;
                    next_state     = ST_DUMP;
                end else begin
                    next_step = 1'b1;
                end
            end

            ST_DUMP: begin
                // rx bytes are dropped here
                if (i_dump_done) begin
                    next_state = ret_debug ? ST_DEBUG : ST_IDLE;
                    next_start = ret_debug;
                end
            end

            default: next_state = ST_IDLE;
        endcase
    end

    // only load mode bytes reach the loader
    assign o_load_byte  = '{strobe: i_rx.strobe && (state == ST_LOAD), data: i_rx.data};
    assign o_load_start = load_start;
    assign o_dump_req   = dump_req;
    assign o_step       = step;
    assign o_start      = start;

    // core must stay frozen while the latches are shipped out
    assert property (@(posedge clk) disable iff (!i_rst_n)
        (state == ST_DUMP) |-> !o_step);

    // one request per dump, the sender would otherwise restart
    assert property (@(posedge clk) disable iff (!i_rst_n)
        o_dump_req |=> !o_dump_req);

endmodule

// File: logic/instr_loader.sv
`timescale 1ns/1ps

module instr_loader import dbg_pkg::*; (
    input  logic      clk,
    input  logic      i_rst_n,
    input  rx_byte_t  i_load_byte,
    input  logic      i_load_start,
    output instr_wr_t o_instr,
    output logic      o_halt
);

    // byte position inside the word, 3 means the word completes
    logic [1:0] byte_cnt;
    logic [1:0] cnt_eff;
    word_t      word_q;
    word_t      addr_q;
    logic       wr_q;

    // a fresh load forgets any half word left over
    assign cnt_eff = i_load_start ? 2'd0 : byte_cnt;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            byte_cnt <= 2'd0;
            addr_q   <= '0;
            wr_q     <= 1'b0;
        end else begin
            wr_q <= i_load_byte.strobe && (cnt_eff == 2'd3);
            if (i_load_byte.strobe) begin
                // wraps back to 0 after the fourth byte
                byte_cnt <= cnt_eff + 2'd1;
            end else if (i_load_start) begin
                byte_cnt <= 2'd0;
            end
            if (i_load_start) begin
                addr_q <= '0;
            end else if (wr_q) begin
                // next word goes 4 bytes further
                addr_q <= addr_q + word_t'(4);
            end
        end
    end

    // first byte ends up most significant
    always_ff @(posedge clk) begin
        if (i_load_byte.strobe) begin
            word_q <= {word_q[NB_WORD-NB_BYTE-1:0], i_load_byte.data};
        end
    end

    // word and address hold steady through the write cycle
    assign o_instr = '{wr: wr_q, instr: word_q, addr: addr_q};
    assign o_halt  = wr_q && (word_q == HALT_INSTR);

    // a write always follows the byte that completed it
    assert property (@(posedge clk) disable iff (!i_rst_n)
        o_instr.wr |-> $past(i_load_byte.strobe));

endmodule

// File: logic/snapshot_sender.sv
`timescale 1ns/1ps

module snapshot_sender import dbg_pkg::*; (
    input  logic      clk,
    input  logic      i_rst_n,
    input  logic      i_dump_req,
    input  snapshot_t i_snapshot,
    input  logic      i_tx_done,
    output logic      o_tx_start,
    output byte_t     o_tx_data,
    output logic      o_dump_done
);

    // captured latches, byte 0 always sits at the bottom
    logic [$bits(snapshot_t)-1:0] shift_q;
    // bytes handed to the transmitter so far
    snap_cnt_t sent_cnt;
    logic      busy;
    logic      tx_start_q;
    logic      dump_done_q;
    logic      capture;
    logic      tx_ack;
    logic      last_byte;

    assign capture   = i_dump_req && !busy;
    // done can't belong to a byte started this very cycle
    assign tx_ack    = busy && i_tx_done && !tx_start_q;
    assign last_byte = (sent_cnt == snap_cnt_t'(SNAP_BYTES));

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy        <= 1'b0;
            sent_cnt    <= '0;
            tx_start_q  <= 1'b0;
            dump_done_q <= 1'b0;
        end else begin
            tx_start_q  <= 1'b0;
            dump_done_q <= 1'b0;
            if (capture) begin
                // first byte goes out right away
                busy       <= 1'b1;
                sent_cnt   <= snap_cnt_t'(1);
                tx_start_q <= 1'b1;
            end else if (tx_ack) begin
                if (last_byte) begin
                    busy        <= 1'b0;
                    dump_done_q <= 1'b1;
                end else begin
                    sent_cnt   <= sent_cnt + snap_cnt_t'(1);
                    tx_start_q <= 1'b1;
                end
            end
        end
    end

    // shift only when another byte follows so the last one stays put
    always_ff @(posedge clk) begin
        if (capture) begin
            shift_q <= i_snapshot;
        end else if (tx_ack && !last_byte) begin
            shift_q <= shift_q >> NB_BYTE;
        end
    end

    assign o_tx_start  = tx_start_q;
    assign o_tx_data   = shift_q[NB_BYTE-1:0];
    assign o_dump_done = dump_done_q;

    // the transmitter takes one start per byte
    assert property (@(posedge clk) disable iff (!i_rst_n)
        o_tx_start |=> !o_tx_start);

endmodule

// File: logic/uart_debug_unit.sv
`timescale 1ns/1ps

module uart_debug_unit import dbg_pkg::*; (
    input  logic      clk,
    input  logic      i_rst_n,
    input  logic      i_rx_done,
    input  byte_t     i_rx,
    input  logic      i_tx_done,
    input  logic      i_end,
    input  snapshot_t i_snapshot,
    output logic      o_tx_start,
    output byte_t     o_tx_data,
    output instr_wr_t o_instr,
    output logic      o_step,
    output logic      o_start
);

    // receiver byte and its strobe travel together from here on
    rx_byte_t rx;
    rx_byte_t load_byte;
    logic     load_start;
    logic     halt;
    logic     dump_req;
    logic     dump_done;

    assign rx = '{strobe: i_rx_done, data: i_rx};

    // command decode and mode control
    debug_ctrl ctrl_i (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_rx         (rx),
        .i_halt       (halt),
        .i_end        (i_end),
        .i_dump_done  (dump_done),
        .o_load_byte  (load_byte),
        .o_load_start (load_start),
        .o_dump_req   (dump_req),
        .o_step       (o_step),
        .o_start      (o_start)
    );

    // word assembly for instruction memory
    instr_loader loader_i (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_load_byte  (load_byte),
        .i_load_start (load_start),
        .o_instr      (o_instr),
        .o_halt       (halt)
    );

    // latch dump toward the uart transmitter
    snapshot_sender sender_i (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_dump_req  (dump_req),
        .i_snapshot  (i_snapshot),
        .i_tx_done   (i_tx_done),
        .o_tx_start  (o_tx_start),
        .o_tx_data   (o_tx_data),
        .o_dump_done (dump_done)
    );

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module uart_debug_unit_tb -f sim.f \
    && ./obj_dir/Vuart_debug_unit_tb | tee sim.log \
    && grep -q "Test completed successfully" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: sim.f
logic/dbg_pkg.sv
logic/debug_ctrl.sv
logic/instr_loader.sv
logic/snapshot_sender.sv
logic/uart_debug_unit.sv
bench/uart_debug_unit_tb.sv
